// File: bench/clockGen.sv
// Testbench clock and reset source, 20 unit clock period with reset held for two cycles
module clockGen (
    output logic clk,
    output logic rst
);

    localparam int HalfPeriod  = 10;
    localparam int ResetCycles = 2;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #HalfPeriod clk = ~clk;
        end
    end

    // Release just after an edge so no flop sees it change on the edge itself
    initial
    begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: bench/decodeStimulus.txt
# stall instr pc regValue1 regValue2 | imm memWrite memRead regWrite aluSrc pcSrc aluOp
# aluControl branchType regDest pcOut value1 value2 (hex, expected part unused on stall rows)
0 123452b7 1000 a01 b01 12345000 0 0 1 1 0 4 2 0 5 ffc a01 b01
0 fffff317 1004 a02 b02 fffff000 0 0 1 1 0 5 2 0 6 1000 a02 b02
0 ff9ff0ef 1008 a03 b03 fffffff8 0 0 1 0 1 3 2 0 1 1004 a03 b03
0 00c08067 100c a04 b04 c 0 0 1 0 1 7 2 0 0 1008 a04 b04
0 ffc101e7 1010 a05 b05 fffffffc 0 0 1 0 1 7 2 0 3 100c a05 b05
0 ffc111e7 1014 a06 b06 0 0 0 1 0 1 7 2 0 3 1010 a06 b06
0 ff042383 1018 a07 b07 fffffff0 0 1 1 1 0 0 2 0 7 1014 a07 b07
0 00952a23 101c a08 b08 14 1 0 0 1 0 0 2 0 14 1018 a08 b08
0 fe110fa3 1020 a09 b09 ffffffff 1 0 0 1 0 0 2 0 1f 101c a09 b09
0 00208863 1024 a0a b0a 10 0 0 0 0 1 1 4 0 10 1020 a0a b0a
0 fe41d0e3 1028 a0b b0b ffffffe0 0 0 0 0 1 1 4 5 1 1024 a0b b0b
0 00629263 102c a0c b0c 4 0 0 0 0 1 1 4 1 4 1028 a0c b0c
0 7ff08193 1030 a0d b0d 7ff 0 0 1 1 0 2 2 0 3 102c a0d b0d
0 00509193 1034 a0e b0e 5 0 0 1 1 0 2 6 0 3 1030 a0e b0e
0 fff0a193 1038 a0f b0f ffffffff 0 0 1 1 0 2 9 0 3 1034 a0f b0f
0 0010b193 103c a10 b10 1 0 0 1 1 0 2 a 0 3 1038 a10 b10
0 0ff0c193 1040 a11 b11 ff 0 0 1 1 0 2 3 0 3 103c a11 b11
0 0030d193 1044 a12 b12 3 0 0 1 1 0 2 7 0 3 1040 a12 b12
0 4030d193 1048 a13 b13 403 0 0 1 1 0 2 8 0 3 1044 a13 b13
0 5550e193 104c a14 b14 555 0 0 1 1 0 2 1 0 3 1048 a14 b14
0 8000f193 1050 a15 b15 fffff800 0 0 1 1 0 2 0 0 3 104c a15 b15
0 2030d193 1054 a16 b16 203 0 0 1 1 0 2 0 0 3 1050 a16 b16
0 002081b3 1058 a17 b17 0 0 0 1 0 0 2 2 0 3 1054 a17 b17
0 402081b3 105c a18 b18 0 0 0 1 0 0 2 4 0 3 1058 a18 b18
0 002091b3 1060 a19 b19 0 0 0 1 0 0 2 6 0 3 105c a19 b19
0 0020a1b3 1064 a1a b1a 0 0 0 1 0 0 2 9 0 3 1060 a1a b1a
0 0020b1b3 1068 a1b b1b 0 0 0 1 0 0 2 a 0 3 1064 a1b b1b
0 0020c1b3 106c a1c b1c 0 0 0 1 0 0 2 3 0 3 1068 a1c b1c
0 0020d1b3 1070 a1d b1d 0 0 0 1 0 0 2 7 0 3 106c a1d b1d
0 4020d1b3 1074 a1e b1e 0 0 0 1 0 0 2 8 0 3 1070 a1e b1e
0 0020e1b3 1078 a1f b1f 0 0 0 1 0 0 2 1 0 3 1074 a1f b1f
0 0020f1b3 107c a20 b20 0 0 0 1 0 0 2 0 0 3 1078 a20 b20
0 022081b3 1080 a21 b21 0 0 0 1 0 0 2 b 0 3 107c a21 b21
0 022091b3 1084 a22 b22 0 0 0 1 0 0 2 c 0 3 1080 a22 b22
0 0220a1b3 1088 a23 b23 0 0 0 1 0 0 2 d 0 3 1084 a23 b23
0 0220b1b3 108c a24 b24 0 0 0 1 0 0 2 e 0 3 1088 a24 b24
0 0220c1b3 1090 a25 b25 0 0 0 1 0 0 2 f 0 3 108c a25 b25
0 0220d1b3 1094 a26 b26 0 0 0 1 0 0 2 10 0 3 1090 a26 b26
0 0220e1b3 1098 a27 b27 0 0 0 1 0 0 2 11 0 3 1094 a27 b27
0 0220f1b3 109c a28 b28 0 0 0 1 0 0 2 12 0 3 1098 a28 b28
0 202081b3 10a0 a29 b29 0 0 0 1 0 0 2 0 0 3 109c a29 b29
0 402091b3 10a4 a2a b2a 0 0 0 1 0 0 2 0 0 3 10a0 a2a b2a
0 0020a1af 10a8 a2b b2b 0 0 0 0 0 0 0 0 0 3 10a4 a2b b2b
0 300022f3 10ac a2c b2c 0 0 0 0 0 0 0 0 0 5 10a8 a2c b2c
0 00a00093 10b0 a2d b2d a 0 0 1 1 0 2 2 0 1 10ac a2d b2d
1 123452b7 10b4 e00 f00 0 0 0 0 0 0 0 0 0 0 0 0 0
1 123452b7 10b4 e01 f01 0 0 0 0 0 0 0 0 0 0 0 0 0
1 123452b7 10b4 e02 f02 0 0 0 0 0 0 0 0 0 0 0 0 0
0 00108133 10b8 a31 b31 0 0 0 1 0 0 2 2 0 2 10b4 a31 b31
0 40110233 10bc a32 b32 0 0 0 1 0 0 2 4 0 4 10b8 a32 b32
0 ff042383 10c0 a33 b33 fffffff0 0 1 1 1 0 0 2 0 7 10bc a33 b33

// File: bench/decodeTb.sv
// Decode stage testbench, replays stimulus vectors and checks every decoded output
module decodeTb;

    import decodePkg::*;

    localparam int    ClkPeriod  = 20;
    localparam int    DriveDelay = 2;
    localparam string StimFile   = "bench/decodeStimulus.txt";

    // One stimulus line, inputs first and expected outputs after
    typedef struct {
        int          index;
        logic [31:0] stall;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] regValue1;
        logic [31:0] regValue2;
        logic [31:0] imm;
        logic [31:0] memWrite;
        logic [31:0] memRead;
        logic [31:0] regWrite;
        logic [31:0] aluSrc;
        logic [31:0] pcSrc;
        logic [31:0] aluOp;
        logic [31:0] aluControl;
        logic [31:0] branchType;
        logic [31:0] regDest;
        logic [31:0] pcOut;
        logic [31:0] value1;
        logic [31:0] value2;
    } vectorT;

    logic                    clk;
    logic                    rst;
    logic                    stall;
    logic [XLen-1:0]         nextInstruction;
    logic [XLen-1:0]         pc;
    logic [XLen-1:0]         regValue1;
    logic [XLen-1:0]         regValue2;
    logic [RegAddrWidth-1:0] rs1Addr;
    logic [RegAddrWidth-1:0] rs2Addr;
    logic [XLen-1:0]         imm;
    logic                    memWrite;
    logic                    memRead;
    logic                    regWrite;
    logic [RegAddrWidth-1:0] regDest;
    logic                    aluSrc;
    aluOpT                   aluOp;
    aluCtrlT                 aluControl;
    logic                    pcSrc;
    logic [2:0]              branchType;
    logic [XLen-1:0]         pcOut;
    logic [XLen-1:0]         value1;
    logic [XLen-1:0]         value2;

    vectorT vectors[$];
    // Instructions sampled but not yet on the outputs
    vectorT pending[$];
    vectorT heldExp;
    int     errorCount;
    int     checkCount;
    bit     vectorsLoaded;
    bit     loadOk;

    clockGen clockGen_i (.clk, .rst);

    decodeTop dut_i (
        .clk, .rst, .stall,
        .nextInstruction, .pc, .regValue1, .regValue2,
        .rs1Addr, .rs2Addr, .imm,
        .memWrite, .memRead, .regWrite, .regDest,
        .aluSrc, .aluOp, .aluControl, .pcSrc, .branchType,
        .pcOut, .value1, .value2
    );

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic string opcodeName(input logic [31:0] instr);
        opcodeT op;
        string  name;
        op   = opcodeT'(instr[6:0]);
        name = op.name();
        if (name == "")
        begin
            name = "unknown opcode";
        end
        return name;
    endfunction

    // Expected outputs of a NOP, only pcOut differs between uses
    function automatic vectorT nopEntry(input logic [31:0] pcOutValue);
        vectorT e;
        e       = '{default: 0};
        e.pcOut = pcOutValue;
        return e;
    endfunction

    task automatic compareOutputs(input vectorT exp, input string label);
        string tag;
        tag = $sformatf("%s vector %0d (%s)", label, exp.index, opcodeName(exp.instr));
        checkValue({tag, " imm"}, imm, exp.imm);
        checkValue({tag, " memWrite"}, memWrite, exp.memWrite);
        checkValue({tag, " memRead"}, memRead, exp.memRead);
        checkValue({tag, " regWrite"}, regWrite, exp.regWrite);
        checkValue({tag, " aluSrc"}, aluSrc, exp.aluSrc);
        checkValue({tag, " pcSrc"}, pcSrc, exp.pcSrc);
        checkValue({tag, " aluOp"}, aluOp, exp.aluOp);
        checkValue({tag, " aluControl"}, aluControl, exp.aluControl);
        checkValue({tag, " branchType"}, branchType, exp.branchType);
        checkValue({tag, " regDest"}, regDest, exp.regDest);
        checkValue({tag, " pcOut"}, pcOut, exp.pcOut);
        checkValue({tag, " value1"}, value1, exp.value1);
        checkValue({tag, " value2"}, value2, exp.value2);
    endtask

    task automatic readVectors(output bit ok);
        int     fd;
        int     fields;
        string  line;
        vectorT v;
        ok = 1'b0;
        fd = $fopen(StimFile, "r");
        if (fd == 0)
        begin
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            // Skip comments and blank lines
            if (line.len() < 2 || line[0] == "#")
            begin
                continue;
            end
            fields = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                v.stall, v.instr, v.pc, v.regValue1, v.regValue2, v.imm,
                v.memWrite, v.memRead, v.regWrite, v.aluSrc, v.pcSrc,
                v.aluOp, v.aluControl, v.branchType, v.regDest, v.pcOut,
                v.value1, v.value2);
            if (fields != 18)
            begin
                errorCount++;
                $display("A stimulus line has %0d fields instead of 18 and was skipped", fields);
            end
            else
            begin
                v.index = vectors.size() + 1;
                vectors.push_back(v);
            end
        end
        $fclose(fd);
        ok = (vectors.size() > 0);
    endtask

    task automatic applyVector(input vectorT v);
        vectorT exp;
        stall           = (v.stall != 0);
        nextInstruction = v.instr;
        pc              = v.pc;
        regValue1       = v.regValue1;
        regValue2       = v.regValue2;
        @(posedge clk);
        #1;
        if (!stall)
        begin
            // Instruction sampled at the previous sampling edge is on the outputs now
            exp = pending.pop_front();
            compareOutputs(exp, "decode");
            heldExp = exp;
            pending.push_back(v);
        end
        else
        begin
            compareOutputs(heldExp, "stall hold");
        end
        // rs fields of the instruction now held in the latch
        checkValue($sformatf("rs1Addr at vector %0d", v.index), rs1Addr,
                   pending[0].instr[19:15]);
        checkValue($sformatf("rs2Addr at vector %0d", v.index), rs2Addr,
                   pending[0].instr[24:20]);
        #(DriveDelay - 1);
    endtask

    task automatic runTests();
        vectorT exp;
        @(negedge rst);
        #1;
        compareOutputs(nopEntry(32'h0), "reset");
        checkValue("reset rs1Addr", rs1Addr, 32'h0);
        checkValue("reset rs2Addr", rs2Addr, 32'h0);
        @(posedge clk);
        #DriveDelay;
        // Latch leaves reset with an all-zero instruction at pc 0
        heldExp = nopEntry(32'hffff_fffc);
        pending.push_back(heldExp);
        foreach (vectors[i])
        begin
            applyVector(vectors[i]);
        end
        // One more NOP cycle brings the last instruction out
        stall           = 1'b0;
        nextInstruction = '0;
        pc              = '0;
        regValue1       = '0;
        regValue2       = '0;
        @(posedge clk);
        #1;
        exp = pending.pop_front();
        compareOutputs(exp, "final");
    endtask

    initial
    begin
        errorCount      = 0;
        checkCount      = 0;
        vectorsLoaded   = 1'b0;
        stall           = 1'b0;
        nextInstruction = '0;
        pc              = '0;
        regValue1       = '0;
        regValue2       = '0;
        readVectors(loadOk);
        if (!loadOk)
        begin
            $display("The stimulus file %s could not be read or holds no vectors", StimFile);
            $display("TEST RESULT: FAIL");
        end
        else
        begin
            vectorsLoaded = 1'b1;
            runTests();
            $display("Decode test finished with %0d checks and %0d errors",
                     checkCount, errorCount);
            if (errorCount == 0)
            begin
                $display("TEST RESULT: PASS");
            end
            else
            begin
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

    // Watchdog, ten spare cycles beyond one cycle per vector
    initial
    begin
        wait (vectorsLoaded);
        #((vectors.size() + 10) * ClkPeriod);
        $display("Timeout, the run did not finish within %0d clock cycles",
                 vectors.size() + 10);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: source/aluControlDecoder.sv
// ALU control decoder, picks the ALU function from opcode, func3 and func7 incl. RV32M
module aluControlDecoder (
    input  logic [decodePkg::XLen-1:0] instruction,
    output decodePkg::aluCtrlT         aluControl
);

    import decodePkg::*;

    opcodeT     opcode;
    logic [2:0] func3;
    logic [6:0] func7;

    assign opcode = opcodeT'(instruction[6:0]);
    assign func3  = instruction[14:12];
    assign func7  = instruction[31:25];

    always_comb
    begin
        aluControl = aluAnd;
        case (opcode)
            // Address and link computations all add
            opLui, opAuipc, opJal, opJalr, opLoad, opStore:
                aluControl = aluAdd;
            // Compare by subtraction
            opBranch:
                aluControl = aluSub;
            opImm:
            begin
                case (func3)
                    3'b000: aluControl = aluAdd;
                    3'b001: aluControl = aluSll;
                    3'b010: aluControl = aluSlt;
                    3'b011: aluControl = aluSltu;
                    3'b100: aluControl = aluXor;
                    3'b110: aluControl = aluOr;
                    3'b111: aluControl = aluAnd;
                    // SRLI or SRAI by func7
                    3'b101:
                    begin
                        if (func7 == func7Base)
                        begin
                            aluControl = aluSrl;
                        end
                        else if (func7 == func7Alt)
                        begin
                            aluControl = aluSra;
                        end
                    end
                    default: aluControl = aluAnd;
                endcase
            end
            opReg:
            begin
                if (func7 == func7Base)
                begin
                    case (func3)
                        3'b000: aluControl = aluAdd;
                        3'b001: aluControl = aluSll;
                        3'b010: aluControl = aluSlt;
                        3'b011: aluControl = aluSltu;
                        3'b100: aluControl = aluXor;
                        3'b101: aluControl = aluSrl;
                        3'b110: aluControl = aluOr;
                        default: aluControl = aluAnd;
                    endcase
                end
                else if (func7 == func7Alt)
                begin
                    // Only SUB and SRA exist here
                    if (func3 == 3'b000)
                    begin
                        aluControl = aluSub;
                    end
                    else if (func3 == 3'b101)
                    begin
                        aluControl = aluSra;
                    end
                end
                else if (func7 == func7MulDiv)
                begin
                    // RV32M multiply and divide
                    case (func3)
                        3'b000: aluControl = aluMul;
                        3'b001: aluControl = aluMulh;
                        3'b010: aluControl = aluMulhsu;
                        3'b011: aluControl = aluMulhu;
                        3'b100: aluControl = aluDiv;
                        3'b101: aluControl = aluDivu;
                        3'b110: aluControl = aluRem;
                        default: aluControl = aluRemu;
                    endcase
                end
            end
            default:
                aluControl = aluAnd;
        endcase
    end

endmodule

// File: source/controlDecoder.sv
// Main control decoder, maps the opcode to memory, writeback, ALU source and PC controls
module controlDecoder (
    input  logic [decodePkg::XLen-1:0] instruction,
    output logic                       memWrite,
    output logic                       memRead,
    output logic                       regWrite,
    output logic                       aluSrc,
    output logic                       pcSrc,
    output decodePkg::aluOpT           aluOp,
    output logic [2:0]                 branchType
);

    import decodePkg::*;

    opcodeT opcode;

    assign opcode = opcodeT'(instruction[6:0]);

    always_comb
    begin
        // Anything unknown falls through as a NOP
        memWrite   = 1'b0;
        memRead    = 1'b0;
        regWrite   = 1'b0;
        aluSrc     = 1'b0;
        pcSrc      = 1'b0;
        aluOp      = aluOpMem;
        branchType = 3'b000;

        case (opcode)
            opLui:
            begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = aluOpLui;
            end
            opAuipc:
            begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = aluOpAuipc;
            end
            opJal:
            begin
                regWrite = 1'b1;
                pcSrc    = 1'b1;
                aluOp    = aluOpJal;
            end
            opJalr:
            begin
                regWrite = 1'b1;
                pcSrc    = 1'b1;
                aluOp    = aluOpJalr;
            end
            // Branch condition comes from func3
            opBranch:
            begin
                pcSrc      = 1'b1;
                aluOp      = aluOpBranch;
                branchType = instruction[14:12];
            end
            opLoad:
            begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            opStore:
            begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            opImm:
            begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = aluOpArith;
            end
            opReg:
            begin
                regWrite = 1'b1;
                aluOp    = aluOpArith;
            end
            default:
                aluOp = aluOpMem;
        endcase
    end

endmodule

// File: source/decodeOutputReg.sv
// Decode output register, second stage holding decoded controls, immediate and operands
module decodeOutputReg (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                stall,
    input  logic [decodePkg::XLen-1:0]          immDec,
    input  logic                                memWriteDec,
    input  logic                                memReadDec,
    input  logic                                regWriteDec,
    input  logic                                aluSrcDec,
    input  logic                                pcSrcDec,
    input  decodePkg::aluOpT                    aluOpDec,
    input  logic [2:0]                          branchTypeDec,
    input  decodePkg::aluCtrlT                  aluControlDec,
    input  logic [decodePkg::XLen-1:0]          instruction,
    input  logic [decodePkg::XLen-1:0]          pcLatched,
    input  logic [decodePkg::XLen-1:0]          value1Latched,
    input  logic [decodePkg::XLen-1:0]          value2Latched,
    output logic [decodePkg::XLen-1:0]          imm,
    output logic                                memWrite,
    output logic                                memRead,
    output logic                                regWrite,
    output logic                                aluSrc,
    output logic                                pcSrc,
    output decodePkg::aluOpT                    aluOp,
    output logic [2:0]                          branchType,
    output decodePkg::aluCtrlT                  aluControl,
    output logic [decodePkg::RegAddrWidth-1:0]  regDest,
    output logic [decodePkg::XLen-1:0]          pcOut,
    output logic [decodePkg::XLen-1:0]          value1,
    output logic [decodePkg::XLen-1:0]          value2
);

    import decodePkg::*;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            imm        <= '0;
            memWrite   <= 1'b0;
            memRead    <= 1'b0;
            regWrite   <= 1'b0;
            aluSrc     <= 1'b0;
            pcSrc      <= 1'b0;
            aluOp      <= aluOpMem;
            branchType <= 3'b000;
            aluControl <= aluAnd;
            regDest    <= '0;
            pcOut      <= '0;
            value1     <= '0;
            value2     <= '0;
        end
        else if (!stall)
        begin
            imm        <= immDec;
            memWrite   <= memWriteDec;
            memRead    <= memReadDec;
            regWrite   <= regWriteDec;
            aluSrc     <= aluSrcDec;
            pcSrc      <= pcSrcDec;
            aluOp      <= aluOpDec;
            branchType <= branchTypeDec;
            aluControl <= aluControlDec;
            // rd field passes through even for a NOP
            regDest    <= instruction[7 +: RegAddrWidth];
            // Fetch has already moved one instruction ahead
            pcOut      <= pcLatched - XLen'(InstrBytes);
            value1     <= value1Latched;
            value2     <= value2Latched;
        end
    end

endmodule

// File: source/decodePkg.sv
// Decode package with RV32 widths, opcode and ALU encodings shared by the decode stage
package decodePkg;

    // Register and data width
    localparam int XLen = 32;

    // Register file address width
    localparam int RegAddrWidth = 5;

    // Size of one instruction in bytes
    localparam int InstrBytes = 4;

    // Major opcodes kept by the decoder
    typedef enum logic [6:0]
    {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011
    } opcodeT;

    // ALU operation class seen by the execute stage
    typedef enum logic [2:0]
    {
        aluOpMem    = 3'd0,
        aluOpBranch = 3'd1,
        aluOpArith  = 3'd2,
        aluOpJal    = 3'd3,
        aluOpLui    = 3'd4,
        aluOpAuipc  = 3'd5,
        aluOpJalr   = 3'd7
    } aluOpT;

    // ALU function select, code 5 is not used
    typedef enum logic [4:0]
    {
        aluAnd    = 5'd0,
        aluOr     = 5'd1,
        aluAdd    = 5'd2,
        aluXor    = 5'd3,
        aluSub    = 5'd4,
        aluSll    = 5'd6,
        aluSrl    = 5'd7,
        aluSra    = 5'd8,
        aluSlt    = 5'd9,
        aluSltu   = 5'd10,
        aluMul    = 5'd11,
        aluMulh   = 5'd12,
        aluMulhsu = 5'd13,
        aluMulhu  = 5'd14,
        aluDiv    = 5'd15,
        aluDivu   = 5'd16,
        aluRem    = 5'd17,
        aluRemu   = 5'd18
    } aluCtrlT;

    // func7 field values
    localparam logic [6:0] func7Base   = 7'h00;
    localparam logic [6:0] func7Alt    = 7'h20;
    localparam logic [6:0] func7MulDiv = 7'h01;

endpackage

// File: source/decodeTop.sv
// Decode stage top, latch then combinational decoders then output register
module decodeTop (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                stall,
    input  logic [decodePkg::XLen-1:0]          nextInstruction,
    input  logic [decodePkg::XLen-1:0]          pc,
    input  logic [decodePkg::XLen-1:0]          regValue1,
    input  logic [decodePkg::XLen-1:0]          regValue2,
    output logic [decodePkg::RegAddrWidth-1:0]  rs1Addr,
    output logic [decodePkg::RegAddrWidth-1:0]  rs2Addr,
    output logic [decodePkg::XLen-1:0]          imm,
    output logic                                memWrite,
    output logic                                memRead,
    output logic                                regWrite,
    output logic [decodePkg::RegAddrWidth-1:0]  regDest,
    output logic                                aluSrc,
    output decodePkg::aluOpT                    aluOp,
    output decodePkg::aluCtrlT                  aluControl,
    output logic                                pcSrc,
    output logic [2:0]                          branchType,
    output logic [decodePkg::XLen-1:0]          pcOut,
    output logic [decodePkg::XLen-1:0]          value1,
    output logic [decodePkg::XLen-1:0]          value2
);

    // First stage contents
    logic [decodePkg::XLen-1:0] instruction;
    logic [decodePkg::XLen-1:0] pcLatched;
    logic [decodePkg::XLen-1:0] value1Latched;
    logic [decodePkg::XLen-1:0] value2Latched;

    // Combinational decode results
    logic [decodePkg::XLen-1:0] immDec;
    logic                       memWriteDec;
    logic                       memReadDec;
    logic                       regWriteDec;
    logic                       aluSrcDec;
    logic                       pcSrcDec;
    decodePkg::aluOpT           aluOpDec;
    logic [2:0]                 branchTypeDec;
    decodePkg::aluCtrlT         aluControlDec;

    instrLatch instrLatch_i (
        .clk, .rst, .stall,
        .nextInstruction, .pc, .regValue1, .regValue2,
        .instruction, .pcLatched, .value1Latched, .value2Latched,
        .rs1Addr, .rs2Addr
    );

    immGenerator immGenerator_i (
        .instruction,
        .imm         (immDec)
    );

    controlDecoder controlDecoder_i (
        .instruction,
        .memWrite    (memWriteDec),
        .memRead     (memReadDec),
        .regWrite    (regWriteDec),
        .aluSrc      (aluSrcDec),
        .pcSrc       (pcSrcDec),
        .aluOp       (aluOpDec),
        .branchType  (branchTypeDec)
    );

    aluControlDecoder aluControlDecoder_i (
        .instruction,
        .aluControl  (aluControlDec)
    );

    decodeOutputReg decodeOutputReg_i (
        .clk, .rst, .stall,
        .immDec, .memWriteDec, .memReadDec, .regWriteDec, .aluSrcDec, .pcSrcDec,
        .aluOpDec, .branchTypeDec, .aluControlDec,
        .instruction, .pcLatched, .value1Latched, .value2Latched,
        .imm, .memWrite, .memRead, .regWrite, .aluSrc, .pcSrc,
        .aluOp, .branchType, .aluControl,
        .regDest, .pcOut, .value1, .value2
    );

endmodule

// File: source/immGenerator.sv
// Immediate generator, builds the sign-extended immediate for each RV32I format
module immGenerator (
    input  logic [decodePkg::XLen-1:0] instruction,
    output logic [decodePkg::XLen-1:0] imm
);

    import decodePkg::*;

    opcodeT     opcode;
    logic [2:0] func3;

    assign opcode = opcodeT'(instruction[6:0]);
    assign func3  = instruction[14:12];

    always_comb
    begin
        imm = '0;
        case (opcode)
            // U format, no sign extension needed
            opLui, opAuipc:
                imm = {instruction[31:12], 12'b0};
            // J format
            opJal:
                imm = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            // JALR only defined for func3 of zero
            opJalr:
            begin
                if (func3 == 3'b000)
                begin
                    imm = {{21{instruction[31]}}, instruction[30:20]};
                end
            end
            // I format
            opLoad, opImm:
                imm = {{21{instruction[31]}}, instruction[30:20]};
            // S format
            opStore:
                imm = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
            // B format, offset in half words
            opBranch:
                imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// File: source/instrLatch.sv
// Instruction latch, first decode register holding instruction, PC and operands
module instrLatch (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                stall,
    input  logic [decodePkg::XLen-1:0]          nextInstruction,
    input  logic [decodePkg::XLen-1:0]          pc,
    input  logic [decodePkg::XLen-1:0]          regValue1,
    input  logic [decodePkg::XLen-1:0]          regValue2,
    output logic [decodePkg::XLen-1:0]          instruction,
    output logic [decodePkg::XLen-1:0]          pcLatched,
    output logic [decodePkg::XLen-1:0]          value1Latched,
    output logic [decodePkg::XLen-1:0]          value2Latched,
    output logic [decodePkg::RegAddrWidth-1:0]  rs1Addr,
    output logic [decodePkg::RegAddrWidth-1:0]  rs2Addr
);

    import decodePkg::*;

    // Hold everything while stalled
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            instruction   <= '0;
            pcLatched     <= '0;
            value1Latched <= '0;
            value2Latched <= '0;
        end
        else if (!stall)
        begin
            instruction   <= nextInstruction;
            pcLatched     <= pc;
            value1Latched <= regValue1;
            value2Latched <= regValue2;
        end
    end

    // Source register fields go straight to the register bank
    assign rs1Addr = instruction[15 +: RegAddrWidth];
    assign rs2Addr = instruction[20 +: RegAddrWidth];

endmodule

// File: vlog.f
source/decodePkg.sv
source/instrLatch.sv
source/immGenerator.sv
source/controlDecoder.sv
source/aluControlDecoder.sv
source/decodeOutputReg.sv
source/decodeTop.sv
bench/clockGen.sv
bench/decodeTb.sv
